// ==== include/tm1638_macros.svh ====
// TM1638 panel parameters

`ifndef TM1638_MACROS_SVH
`define TM1638_MACROS_SVH

// system clocks per eighth of a serial bit period
`define TM_CLK_EIGHTH 2

// link queue entries, power of two
`define LINK_FIFO_DEPTH 4

// digit positions on the board, fixed by the chip
`define PANEL_DIGITS 8

`endif

// ==== verilog/tm1638_link_pkg.sv ====
// TM1638 serial link types

`default_nettype none

package tm1638_link_pkg;

	// what the engine does with a queue entry
	typedef enum logic [0:0] {
		KIND_WRITE = 1'b0,
		KIND_SCAN  = 1'b1
	} link_kind_e;

	// last raises the strobe once the entry is done
	typedef struct packed {
		link_kind_e kind;
		logic [7:0] data;
		logic       last;
	} link_entry_t;

	typedef enum logic [2:0] {
		S_IDLE,
		S_STB_SETUP,
		S_WRITE_BIT,
		S_READ_BIT,
		S_READ_STEP,
		S_STB_RELEASE
	} serial_state_e;

endpackage

`default_nettype wire

// ==== verilog/panel_pkg.sv ====
// TM1638 panel types

`default_nettype none

`include "tm1638_macros.svh"

package panel_pkg;

	typedef enum logic [7:0] {
		OP_DATA_WRITE_AUTO = 8'h40,
		OP_DATA_READ_KEYS  = 8'h42,
		OP_DISPLAY_ON      = 8'h88,
		OP_ADDR_BASE       = 8'hC0
	} panel_op_e;

	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_MODE,
		SEQ_ADDR,
		SEQ_DATA,
		SEQ_BRIGHT,
		SEQ_SCAN
	} panel_seq_state_e;

	// segments[0] is digit 0, leds bit k is LED k
	typedef struct packed {
		logic [`PANEL_DIGITS-1:0][7:0] segments;
		logic [`PANEL_DIGITS-1:0]      leds;
		logic [2:0]                    brightness;
	} panel_image_t;

endpackage

`default_nettype wire

// ==== verilog/panel_sequencer.sv ====
// TM1638 refresh command sequencer

`default_nettype none
`timescale 1ns/100ps

`include "tm1638_macros.svh"

module panel_sequencer
	import tm1638_link_pkg::*;
	import panel_pkg::*;
(
	input  wire          i_clk,
	input  wire          i_rst,
	input  wire          i_refresh,
	input  panel_image_t i_image,
	input  wire          i_full,
	input  wire          i_engine_idle,
	output logic         o_push,
	output link_entry_t  o_entry,
	output logic         o_busy
);

	// index of the final data byte, two bytes per digit
	localparam logic [3:0] LAST_DATA = 4'(2 * `PANEL_DIGITS - 1);

	panel_seq_state_e state;
	panel_image_t     image_q;
	logic [3:0]       byte_idx;
	logic [7:0]       data_byte;
	logic             accept;

	assign accept = (state == SEQ_IDLE) && !o_busy && i_refresh;

	// even index carries segments, odd index the LED in bit 0
	assign data_byte = byte_idx[0] ? {7'b0, image_q.leds[byte_idx[3:1]]}
		: image_q.segments[byte_idx[3:1]];

	assign o_push = (state != SEQ_IDLE) && !i_full;

	always_comb begin
		o_entry.kind = KIND_WRITE;
		o_entry.data = 8'h00;
		o_entry.last = 1'b0;
		case (state)
		SEQ_MODE: begin
			o_entry.data = OP_DATA_WRITE_AUTO;
			o_entry.last = 1'b1;
		end
		SEQ_ADDR: begin
			o_entry.data = OP_ADDR_BASE;
		end
		SEQ_DATA: begin
			o_entry.data = data_byte;
			o_entry.last = (byte_idx == LAST_DATA);
		end
		SEQ_BRIGHT: begin
			o_entry.data = 8'(OP_DISPLAY_ON) | {5'b0, image_q.brightness};
			o_entry.last = 1'b1;
		end
		SEQ_SCAN: begin
			// read command first, then the four byte scan
			if (byte_idx[0]) begin
				o_entry.kind = KIND_SCAN;
				o_entry.last = 1'b1;
			end else begin
				o_entry.data = OP_DATA_READ_KEYS;
			end
		end
		default: begin
			o_entry.data = 8'h00;
		end
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (accept)
			image_q <= i_image;
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state <= SEQ_IDLE;
			byte_idx <= '0;
			o_busy <= 1'b0;
		end else begin
			case (state)
			SEQ_IDLE: begin
				if (accept) begin
					o_busy <= 1'b1;
					byte_idx <= '0;
					state <= SEQ_MODE;
				end else if (o_busy && i_engine_idle) begin
					// scan drained and strobe released
					o_busy <= 1'b0;
				end
			end
			SEQ_MODE: begin
				if (!i_full)
					state <= SEQ_ADDR;
			end
			SEQ_ADDR: begin
				if (!i_full) begin
					byte_idx <= '0;
					state <= SEQ_DATA;
				end
			end
			SEQ_DATA: begin
				if (!i_full) begin
					byte_idx <= byte_idx + 4'd1;
					if (byte_idx == LAST_DATA)
						state <= SEQ_BRIGHT;
				end
			end
			SEQ_BRIGHT: begin
				if (!i_full) begin
					byte_idx <= '0;
					state <= SEQ_SCAN;
				end
			end
			SEQ_SCAN: begin
				if (!i_full) begin
					byte_idx <= byte_idx + 4'd1;
					if (byte_idx[0])
						state <= SEQ_IDLE;
				end
			end
			default: begin
				state <= SEQ_IDLE;
			end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/link_byte_fifo.sv ====
// TM1638 link entry queue

`default_nettype none
`timescale 1ns/100ps

`include "tm1638_macros.svh"

module link_byte_fifo
	import tm1638_link_pkg::*;
(
	input  wire         i_clk,
	input  wire         i_rst,
	input  wire         i_push,
	input  link_entry_t i_entry,
	input  wire         i_pop,
	output link_entry_t o_entry,
	output logic        o_full,
	output logic        o_empty
);

	localparam int ADDR_W = $clog2(`LINK_FIFO_DEPTH);

	link_entry_t mem [`LINK_FIFO_DEPTH];

	// extra msb tells a full wrap from an empty queue
	logic [ADDR_W:0] wr_ptr;
	logic [ADDR_W:0] rd_ptr;
	logic            do_push;
	logic            do_pop;

	assign o_empty = (wr_ptr == rd_ptr);
	assign o_full = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W])
		&& (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

	assign do_push = i_push && !o_full;
	assign do_pop = i_pop && !o_empty;

	// head entry is visible without a pop
	assign o_entry = mem[rd_ptr[ADDR_W-1:0]];

	always_ff @(posedge i_clk) begin
		if (do_push)
			mem[wr_ptr[ADDR_W-1:0]] <= i_entry;
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/tm1638_serial.sv ====
// TM1638 serial engine

`default_nettype none
`timescale 1ns/100ps

`include "tm1638_macros.svh"

module tm1638_serial
	import tm1638_link_pkg::*;
(
	input  wire         i_clk,
	input  wire         i_rst,
	input  link_entry_t i_entry,
	input  wire         i_empty,
	input  wire         i_tm_dio,
	output logic        o_pop,
	output logic        o_idle,
	output logic [7:0]  o_buttons,
	output logic        o_buttons_valid,
	output logic        o_tm_stb,
	output logic        o_tm_clk,
	output logic        o_tm_dio,
	output logic        o_tm_dio_oe
);

	localparam int BIT_CYCLES = `TM_CLK_EIGHTH * 8;
	localparam int CNT_W = $clog2(BIT_CYCLES);

	// counter values are eighths remaining in the bit
	localparam logic [CNT_W-1:0] CNT_TOP = CNT_W'(BIT_CYCLES - 1);
	localparam logic [CNT_W-1:0] CLK_RISE = CNT_W'(`TM_CLK_EIGHTH * 5);
	localparam logic [CNT_W-1:0] CLK_SAMPLE = CNT_W'(`TM_CLK_EIGHTH * 4);
	localparam logic [CNT_W-1:0] CLK_FALL = CNT_W'(`TM_CLK_EIGHTH * 3);

	serial_state_e    state;
	logic [CNT_W-1:0] eighth_cnt;
	logic [2:0]       bit_cnt;
	logic [1:0]       read_cnt;
	logic [7:0]       shift_q;
	logic [7:0]       btn_acc;
	link_kind_e       kind_q;
	logic             last_q;
	logic             bit_end;
	logic             timed;

	function automatic serial_state_e first_state(input link_kind_e kind);
		return (kind == KIND_SCAN) ? S_READ_BIT : S_WRITE_BIT;
	endfunction

	assign o_pop = (state == S_IDLE) && !i_empty;
	assign o_idle = (state == S_IDLE) && i_empty;
	assign bit_end = (eighth_cnt == '0);
	assign timed = (state != S_IDLE) && (state != S_READ_STEP);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state <= S_IDLE;
			eighth_cnt <= CNT_TOP;
			bit_cnt <= '0;
			read_cnt <= '0;
			o_buttons <= '0;
			o_buttons_valid <= 1'b0;
			o_tm_stb <= 1'b1;
			o_tm_clk <= 1'b0;
			o_tm_dio <= 1'b0;
			o_tm_dio_oe <= 1'b0;
		end else begin
			o_buttons_valid <= 1'b0;

			// one bit period, reloads itself at the end
			if (timed)
				eighth_cnt <= bit_end ? CNT_TOP : eighth_cnt - 1'b1;

			// serial clock high between five and three eighths remaining
			if (state == S_WRITE_BIT || state == S_READ_BIT) begin
				if (eighth_cnt == CLK_RISE)
					o_tm_clk <= 1'b1;
				else if (eighth_cnt == CLK_FALL)
					o_tm_clk <= 1'b0;
			end

			case (state)
			S_IDLE: begin
				if (!i_empty) begin
					kind_q <= i_entry.kind;
					shift_q <= i_entry.data;
					last_q <= i_entry.last;
					bit_cnt <= '0;
					read_cnt <= 2'd3;
					eighth_cnt <= CNT_TOP;
					o_tm_dio <= i_entry.data[0];
					// chip drives the line during a scan
					o_tm_dio_oe <= (i_entry.kind == KIND_WRITE);
					if (o_tm_stb) begin
						o_tm_stb <= 1'b0;
						state <= S_STB_SETUP;
					end else begin
						state <= first_state(i_entry.kind);
					end
				end
			end
			S_STB_SETUP: begin
				if (bit_end)
					state <= first_state(kind_q);
			end
			S_WRITE_BIT: begin
				if (bit_end) begin
					if (bit_cnt == 3'd7) begin
						state <= last_q ? S_STB_RELEASE : S_IDLE;
					end else begin
						bit_cnt <= bit_cnt + 3'd1;
						o_tm_dio <= shift_q[bit_cnt + 3'd1];
					end
				end
			end
			S_READ_BIT: begin
				if (eighth_cnt == CLK_SAMPLE)
					shift_q[bit_cnt] <= i_tm_dio;
				if (bit_end) begin
					if (bit_cnt == 3'd7)
						state <= S_READ_STEP;
					else
						bit_cnt <= bit_cnt + 3'd1;
				end
			end
			S_READ_STEP: begin
				// key byte k lands in bits k and k+4 after the last shift
				btn_acc <= {shift_q[4], btn_acc[7:5], shift_q[0], btn_acc[3:1]};
				bit_cnt <= '0;
				read_cnt <= read_cnt - 2'd1;
				if (read_cnt == 2'd0)
					state <= last_q ? S_STB_RELEASE : S_IDLE;
				else
					state <= S_READ_BIT;
			end
			S_STB_RELEASE: begin
				if (eighth_cnt == CNT_TOP)
					o_tm_stb <= 1'b1;
				if (bit_end) begin
					o_tm_dio_oe <= 1'b0;
					if (kind_q == KIND_SCAN) begin
						o_buttons <= btn_acc;
						o_buttons_valid <= 1'b1;
					end
					state <= S_IDLE;
				end
			end
			default: begin
				state <= S_IDLE;
			end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/tm1638_panel.sv ====
// TM1638 panel top level

`default_nettype none
`timescale 1ns/100ps

module tm1638_panel
	import tm1638_link_pkg::*;
	import panel_pkg::*;
(
	input  wire          i_clk,
	input  wire          i_rst,
	input  wire          i_refresh,
	input  panel_image_t i_image,
	output logic         o_busy,
	output logic [7:0]   o_buttons,
	output logic         o_buttons_valid,
	output logic         o_tm_stb,
	output logic         o_tm_clk,
	output logic         o_tm_dio,
	output logic         o_tm_dio_oe,
	input  wire          i_tm_dio
);

	link_entry_t push_entry;
	link_entry_t head_entry;
	logic        push;
	logic        pop;
	logic        full;
	logic        empty;
	logic        engine_idle;

	panel_sequencer u_sequencer (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_refresh     (i_refresh),
		.i_image       (i_image),
		.i_full        (full),
		.i_engine_idle (engine_idle),
		.o_push        (push),
		.o_entry       (push_entry),
		.o_busy        (o_busy)
	);

	link_byte_fifo u_fifo (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_push  (push),
		.i_entry (push_entry),
		.i_pop   (pop),
		.o_entry (head_entry),
		.o_full  (full),
		.o_empty (empty)
	);

	// data pin arrives split, the board wrapper adds the pad
	tm1638_serial u_serial (
		.i_clk           (i_clk),
		.i_rst           (i_rst),
		.i_entry         (head_entry),
		.i_empty         (empty),
		.i_tm_dio        (i_tm_dio),
		.o_pop           (pop),
		.o_idle          (engine_idle),
		.o_buttons       (o_buttons),
		.o_buttons_valid (o_buttons_valid),
		.o_tm_stb        (o_tm_stb),
		.o_tm_clk        (o_tm_clk),
		.o_tm_dio        (o_tm_dio),
		.o_tm_dio_oe     (o_tm_dio_oe)
	);

endmodule

`default_nettype wire

// ==== testbench/tm1638_chip_model.sv ====
// TM1638 behavioral chip

`default_nettype none
`timescale 1ns/100ps

module tm1638_chip_model (
	input  wire        i_clk,
	input  wire        i_rst,
	input  wire        i_stb,
	input  wire        i_sclk,
	input  wire        i_dio,
	input  wire        i_dio_oe,
	input  wire [31:0] i_keys,
	output logic       o_dio
);

	// written bytes, each frame points into the log
	logic [7:0] byte_log [0:511];
	int         frame_start [0:63];
	int         frame_len [0:63];
	int         byte_count;
	int         frame_count;
	int         read_edges;
	int         oe_errors;

	logic       stb_q;
	logic       sclk_q;
	logic [7:0] shift_q;
	logic [2:0] bit_cnt;
	logic       read_mode;
	logic [5:0] rd_idx;
	logic [7:0] next_byte;
	logic       dio_q = 1'b0;

	assign o_dio = dio_q;

	// byte once the current bit is shifted in, lsb first
	assign next_byte = {i_dio, shift_q[7:1]};

	always @(posedge i_clk) begin
		if (i_rst) begin
			stb_q <= 1'b1;
			sclk_q <= 1'b0;
			shift_q <= '0;
			bit_cnt <= '0;
			read_mode <= 1'b0;
			rd_idx <= '0;
			dio_q <= 1'b0;
			byte_count <= 0;
			frame_count <= 0;
			read_edges <= 0;
			oe_errors <= 0;
		end else begin
			stb_q <= i_stb;
			sclk_q <= i_sclk;
			if (!i_stb && stb_q) begin
				frame_start[frame_count] <= byte_count;
				frame_len[frame_count] <= 0;
				bit_cnt <= '0;
				read_mode <= 1'b0;
			end
			if (i_stb && !stb_q) begin
				frame_count <= frame_count + 1;
				read_mode <= 1'b0;
			end
			if (i_sclk && !sclk_q) begin
				if (read_mode) begin
					read_edges <= read_edges + 1;
					if (i_dio_oe)
						oe_errors <= oe_errors + 1;
				end else if (i_dio_oe && !i_stb) begin
					shift_q <= next_byte;
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7) begin
						byte_log[byte_count] <= next_byte;
						byte_count <= byte_count + 1;
						frame_len[frame_count] <= frame_len[frame_count] + 1;
						// read command opens the key scan
						if (next_byte == 8'h42 && frame_len[frame_count] == 0) begin
							read_mode <= 1'b1;
							rd_idx <= '0;
						end
					end
				end
			end
			// key bits go out on the falling clock
			if (!i_sclk && sclk_q && read_mode && rd_idx < 6'd32) begin
				dio_q <= i_keys[rd_idx[4:0]];
				rd_idx <= rd_idx + 6'd1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== testbench/tb_tm1638_panel.sv ====
// TM1638 panel testbench

`default_nettype none
`timescale 1ns/100ps

module tb_tm1638_panel
	import panel_pkg::*;
();

	localparam int ROWS = 6;
	localparam int PASSES = 8;
	localparam int WAIT_LIMIT = 20000;

	logic         clk;
	logic         rst;
	logic         refresh;
	panel_image_t image;
	logic [31:0]  keys;
	logic         busy;
	logic [7:0]   buttons;
	logic         buttons_valid;
	logic         tm_stb;
	logic         tm_clk;
	logic         tm_dio;
	logic         tm_dio_oe;
	logic         chip_dio;

	// stimulus table, brightness comes from the pass number
	panel_image_t row_image [ROWS];
	logic [31:0]  row_keys [ROWS];

	int           errors;
	logic         timed_out;

	tm1638_panel DUT (
		.i_clk           (clk),
		.i_rst           (rst),
		.i_refresh       (refresh),
		.i_image         (image),
		.o_busy          (busy),
		.o_buttons       (buttons),
		.o_buttons_valid (buttons_valid),
		.o_tm_stb        (tm_stb),
		.o_tm_clk        (tm_clk),
		.o_tm_dio        (tm_dio),
		.o_tm_dio_oe     (tm_dio_oe),
		.i_tm_dio        (chip_dio)
	);

	tm1638_chip_model chip (
		.i_clk    (clk),
		.i_rst    (rst),
		.i_stb    (tm_stb),
		.i_sclk   (tm_clk),
		.i_dio    (tm_dio),
		.i_dio_oe (tm_dio_oe),
		.i_keys   (keys),
		.o_dio    (chip_dio)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// digit d segments then LED d in bit 0, one digit after another
	function automatic logic [7:0] expected_data(input panel_image_t img, input int idx);
		logic [7:0] stream [16];
		for (int d = 0; d < 8; d++) begin
			stream[2 * d] = img.segments[d];
			stream[2 * d + 1] = {7'b0, img.leds[d]};
		end
		return stream[idx];
	endfunction

	function automatic logic [7:0] expected_buttons(input logic [31:0] k);
		logic [7:0] b;
		for (int n = 0; n < 4; n++) begin
			b[n] = k[8 * n];
			b[n + 4] = k[8 * n + 4];
		end
		return b;
	endfunction

	task automatic build_table();
		for (int r = 0; r < ROWS; r++) begin
			for (int d = 0; d < 8; d++) begin
				if (r >= 4)
					row_image[r].segments[d] = 8'($urandom);
				else
					row_image[r].segments[d] = 8'(d * 37 + r * 90);
			end
			row_image[r].brightness = '0;
			if (r >= 4) begin
				row_image[r].leds = 8'($urandom);
				row_keys[r] = $urandom;
			end else begin
				row_image[r].leds = 8'h03 << (2 * r);
				// one button set, all other key bits noise
				row_keys[r] = 32'heeee_eeee | (32'h1 << (8 * r + 4 * (r % 2)));
			end
		end
	endtask

	task automatic expect_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			errors++;
			$display("** Error: %s got 0x%h expected 0x%h", what, got, exp);
		end
	endtask

	task automatic check_frames(input int base, input panel_image_t img);
		int start;
		int exp_len;
		if (chip.frame_count != base + 4) begin
			errors++;
			$display("** Error: o_tm_stb frames per refresh got 0x%h expected 0x%h",
				chip.frame_count - base, 4);
			return;
		end
		for (int f = 0; f < 4; f++) begin
			exp_len = (f == 1) ? 17 : 1;
			if (chip.frame_len[base + f] != exp_len) begin
				errors++;
				$display("** Error: o_tm_dio frame %0d length got 0x%h expected 0x%h",
					f, chip.frame_len[base + f], exp_len);
				return;
			end
		end
		expect_byte("o_tm_dio mode command", chip.byte_log[chip.frame_start[base]], 8'h40);
		start = chip.frame_start[base + 1];
		expect_byte("o_tm_dio address command", chip.byte_log[start], 8'hc0);
		for (int i = 0; i < 16; i++)
			expect_byte($sformatf("o_tm_dio display byte %0d", i),
				chip.byte_log[start + 1 + i], expected_data(img, i));
		expect_byte("o_tm_dio display control", chip.byte_log[chip.frame_start[base + 2]],
			8'h88 | {5'b0, img.brightness});
		expect_byte("o_tm_dio read command", chip.byte_log[chip.frame_start[base + 3]], 8'h42);
	endtask

	task automatic wait_busy(input logic level);
		int n;
		n = 0;
		@(negedge clk);
		while (busy !== level && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (busy !== level) begin
			errors++;
			timed_out = 1'b1;
			$display("timeout: o_busy never reached level %0d", level);
		end
	endtask

	task automatic wait_read_start(input int base);
		int n;
		n = 0;
		@(negedge clk);
		while (chip.read_edges == base && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (chip.read_edges == base) begin
			errors++;
			timed_out = 1'b1;
			$display("timeout: key read never started after a refresh");
		end
	endtask

	task automatic wait_buttons_valid();
		int n;
		n = 0;
		@(negedge clk);
		while (buttons_valid !== 1'b1 && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (buttons_valid !== 1'b1) begin
			errors++;
			timed_out = 1'b1;
			$display("timeout: o_buttons_valid never pulsed after a refresh");
		end
	endtask

	initial begin
		int base;
		int read_base;
		int oe_base;
		int row;
		panel_image_t img;

		void'($urandom(32'h96df165a));
		rst = 1'b1;
		refresh = 1'b0;
		image = '0;
		keys = '0;
		errors = 0;
		timed_out = 1'b0;
		build_table();

		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		if (tm_stb !== 1'b1 || tm_clk !== 1'b0 || tm_dio_oe !== 1'b0 || busy !== 1'b0
			|| buttons_valid !== 1'b0 || buttons !== 8'h00) begin
			errors++;
			$display("** Error: reset o_tm_stb=0x%h o_tm_clk=0x%h o_tm_dio_oe=0x%h",
				tm_stb, tm_clk, tm_dio_oe);
			$display("** Error: reset o_busy=0x%h o_buttons_valid=0x%h o_buttons=0x%h",
				busy, buttons_valid, buttons);
		end

		for (int pass = 0; pass < PASSES; pass++) begin
			row = pass % ROWS;
			img = row_image[row];
			img.brightness = pass[2:0];
			base = chip.frame_count;
			read_base = chip.read_edges;
			oe_base = chip.oe_errors;

			@(posedge clk);
			keys <= row_keys[row];
			image <= img;
			refresh <= 1'b1;
			@(posedge clk);
			refresh <= 1'b0;
			wait_busy(1'b1);
			if (timed_out)
				break;

			// second request during the key read, sequencer idle but still busy
			wait_read_start(read_base);
			if (timed_out)
				break;
			@(posedge clk);
			image <= ~img;
			refresh <= 1'b1;
			@(posedge clk);
			refresh <= 1'b0;

			wait_buttons_valid();
			if (timed_out)
				break;
			expect_byte("o_buttons", buttons, expected_buttons(row_keys[row]));
			if (busy !== 1'b1) begin
				errors++;
				$display("** Error: o_busy at o_buttons_valid got 0x%h expected 0x1", busy);
			end
			@(negedge clk);
			if (busy !== 1'b0) begin
				errors++;
				$display("** Error: o_busy after o_buttons_valid got 0x%h expected 0x0", busy);
			end

			// quiet period, no further frame may start
			repeat (64) @(negedge clk);
			check_frames(base, img);
			if (chip.read_edges - read_base != 32) begin
				errors++;
				$display("** Error: o_tm_clk read edges got 0x%h expected 0x%h",
					chip.read_edges - read_base, 32);
			end
			if (chip.oe_errors != oe_base) begin
				errors++;
				$display("** Error: o_tm_dio_oe high during key read on %0d edges",
					chip.oe_errors - oe_base);
			end
		end

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
verilog/tm1638_link_pkg.sv
verilog/panel_pkg.sv
verilog/panel_sequencer.sv
verilog/link_byte_fifo.sv
verilog/tm1638_serial.sv
verilog/tm1638_panel.sv
testbench/tm1638_chip_model.sv
testbench/tb_tm1638_panel.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_tm1638_panel
FILELIST = sim.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
